//--- filelist.f
src/xecuPkg.sv
src/opDecode.sv
src/operandSelect.sv
src/execUnit.sv
src/msrUnit.sv
src/execTop.sv
sim/execTop_assertions.sv
sim/execTb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module execTb \
   -f filelist.f -o execSim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/execSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- sim/execTb.sv
`default_nettype none

module execTb;

   typedef struct packed {
      xecuPkg::opcode_t op;
      xecuPkg::regIdx_t rd;
      xecuPkg::regIdx_t ra;
      xecuPkg::regIdx_t rb;
      xecuPkg::imm_t    imm;
      xecuPkg::word_t   a;
      xecuPkg::word_t   b;
      logic             rndA;
      logic             rndB;
      logic             rndImm;   // Random amount in imm[4:0]
      logic [3:0]       gap;
   } entry_t;

   logic gclk;
   logic grst;
   logic issue;
   xecuPkg::opcode_t opcode;
   xecuPkg::regIdx_t rd;
   xecuPkg::regIdx_t ra;
   xecuPkg::regIdx_t rb;
   xecuPkg::imm_t imm;
   xecuPkg::word_t regA;
   xecuPkg::word_t regB;
   xecuPkg::word_t pc;
   xecuPkg::word_t result;
   logic resultValid;
   xecuPkg::regIdx_t resultRd;
   xecuPkg::word_t dataAddr;
   xecuPkg::byteSel_t dataSel;
   logic msrIe;

   entry_t instrTable[$];
   xecuPkg::word_t expRes[$];
   xecuPkg::regIdx_t expRd[$];
   xecuPkg::word_t expAddr[$];
   xecuPkg::byteSel_t expSel[$];
   logic expIe[$];
   int expCycle[$];

   xecuPkg::word_t rngState = 32'h3718cd71;
   int cycle = 0;

   // Reference state
   logic modelC = 1'b0;
   logic modelIe = 1'b0;
   logic modelBe = 1'b0;
   logic modelBip = 1'b0;
   xecuPkg::regIdx_t prevRd = '0;
   xecuPkg::word_t prevResult = '0;

   execTop dut_i (
      .gclk(gclk), .grst(grst), .issue(issue), .opcode(opcode),
      .rd(rd), .ra(ra), .rb(rb), .imm(imm), .regA(regA), .regB(regB), .pc(pc),
      .result(result), .resultValid(resultValid), .resultRd(resultRd),
      .dataAddr(dataAddr), .dataSel(dataSel), .msrIe(msrIe)
   );

   initial begin
      gclk = 1'b0;
      forever #4 gclk = ~gclk;
   end

   always @(posedge gclk) cycle <= cycle + 1;

   function automatic xecuPkg::word_t nextRand();
      xecuPkg::word_t x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   task automatic stopRun();
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkWord(input string name, input xecuPkg::word_t got,
                            input xecuPkg::word_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
         stopRun();
      end
   endtask

   task automatic checkIdx(input string name, input xecuPkg::regIdx_t got,
                           input xecuPkg::regIdx_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
         stopRun();
      end
   endtask

   task automatic checkSel(input string name, input xecuPkg::byteSel_t got,
                           input xecuPkg::byteSel_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
         stopRun();
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
         stopRun();
      end
   endtask

   task automatic addEntry(input logic [5:0] op, input logic [4:0] d, input logic [4:0] sa,
                           input logic [4:0] sb, input logic [15:0] im,
                           input logic [31:0] a, input logic [31:0] b, input logic rA,
                           input logic rB, input logic rI, input logic [3:0] gap);
      entry_t e;
      e = '{op, d, sa, sb, im, a, b, rA, rB, rI, gap};
      instrTable.push_back(e);
   endtask

   function automatic xecuPkg::byteSel_t laneFor(input logic [1:0] size, input logic [1:0] low);
      if (size == 2'd2) return 4'hF;
      if (size == 2'd1) return low[1] ? 4'h3 : 4'hC;
      return 4'h8 >> low;   // Byte lanes, big-endian
   endfunction

   // Sequential model of one instruction, with the pipeline forwarding rule
   task automatic modelInstr(input entry_t e, input xecuPkg::word_t aIn,
                             input xecuPkg::word_t bIn, input xecuPkg::word_t pcVal,
                             input logic fwdOk, output xecuPkg::word_t res,
                             output xecuPkg::byteSel_t sel);
      xecuPkg::word_t effA;
      xecuPkg::word_t effB;
      xecuPkg::word_t aa;
      logic co;
      logic cin;
      logic isLs;
      logic movePc;
      effA = (fwdOk && e.ra == prevRd && e.ra != 0) ? prevResult : aIn;
      movePc = (e.op == 6'h25) && !e.imm[14] && !e.imm[0];
      if (movePc) effB = pcVal;
      else if (e.op[3]) effB = {{16{e.imm[15]}}, e.imm};
      else effB = (fwdOk && e.rb == prevRd && e.rb != 0) ? prevResult : bIn;
      isLs = (e.op[5:4] == 2'b11) && (e.op[1:0] != 2'b11);
      sel = '0;
      res = '0;
      if (e.op[5:4] == 2'b00) begin
         aa = e.op[0] ? ~effA : effA;
         cin = e.op[1] ? modelC : e.op[0];
         {co, res} = {1'b0, effB} + {1'b0, aa} + {32'd0, cin};
         if (!e.op[2]) modelC = co;
      end else if (e.op[5:4] == 2'b01 && e.op[2:0] == 3'b001) begin
         case (e.imm[10:9])
            2'd1: res = $signed(effA) >>> effB[4:0];
            2'd2: res = effA << effB[4:0];
            default: res = effA >> effB[4:0];
         endcase
      end else if (e.op == 6'h24) begin
         case (e.imm[6:5])
            2'd0: res = {effA[31], effA[31:1]};
            2'd1: res = {modelC, effA[31:1]};
            2'd2: res = {1'b0, effA[31:1]};
            default: res = e.imm[0] ? {{16{effA[15]}}, effA[15:0]}
                                    : {{24{effA[7]}}, effA[7:0]};
         endcase
         if (e.imm[6:5] != 2'd3) modelC = effA[0];
      end else if (e.op == 6'h25) begin
         if (e.imm[14]) begin
            res = effA;
            modelC = effA[xecuPkg::MsrBitC];
            modelIe = effA[xecuPkg::MsrBitIe];
            modelBe = effA[xecuPkg::MsrBitBe];
            modelBip = effA[xecuPkg::MsrBitBip];
         end else if (e.imm[0]) begin
            res = {modelC, 3'b000, xecuPkg::MsrVersion, 4'h0,
                   modelBip, modelC, modelIe, modelBe};
         end else begin
            res = pcVal;
         end
      end else if (e.op[5:4] == 2'b10) begin
         case (e.op[1:0])
            2'd0: res = effA | effB;
            2'd1: res = effA & effB;
            2'd2: res = effA ^ effB;
            default: res = effA & ~effB;
         endcase
      end else begin
         res = effA + effB;
         if (isLs) sel = laneFor(e.op[1:0], res[1:0]);
      end
      prevResult = res;
      prevRd = ((isLs && e.op[2]) || (e.op == 6'h25 && e.imm[14])) ? 5'd0 : e.rd;
   endtask

   // Result monitor, sampled away from the clock edge
   initial begin
      xecuPkg::word_t addrExp;
      xecuPkg::byteSel_t selExp;
      forever begin
         @(posedge gclk);
         #2;
         if (grst) begin
            checkBit("resultValid in reset", resultValid, 1'b0);
         end else if (resultValid) begin
            if (expRes.size() == 0) begin
               $display("Unexpected resultValid strobe at %0t with nothing issued", $time);
               stopRun();
            end else begin
               checkWord("cycle of resultValid", cycle, expCycle.pop_front());
               checkWord("result", result, expRes.pop_front());
               checkIdx("resultRd", resultRd, expRd.pop_front());
               addrExp = expAddr.pop_front();
               selExp = expSel.pop_front();
               if (selExp != 4'h0) begin   // Only loads and stores carry an address
                  checkWord("dataAddr", dataAddr, addrExp);
               end
               checkSel("dataSel", dataSel, selExp);
               checkBit("msrIe", msrIe, expIe.pop_front());
            end
         end else begin
            checkSel("dataSel idle", dataSel, 4'h0);
            if (expCycle.size() != 0 && cycle >= expCycle[0]) begin
               $display("Timeout: resultValid missing at %0t", $time);
               stopRun();
            end
         end
      end
   end

   initial begin
      entry_t e;
      xecuPkg::word_t aVal;
      xecuPkg::word_t bVal;
      xecuPkg::word_t pcVal;
      xecuPkg::word_t res;
      xecuPkg::byteSel_t sel;
      logic fwdOk;
      int waitCount;
      grst = 1'b1;
      issue = 1'b0;
      opcode = '0;
      rd = '0;
      ra = '0;
      rb = '0;
      imm = '0;
      regA = '0;
      regB = '0;
      pc = '0;

      addEntry(6'h00, 3, 1, 2, 16'h0, 32'hFFFFFFFF, 32'h1, 0, 0, 0, 1);
      addEntry(6'h02, 4, 5, 6, 16'h0, 32'h5, 32'h6, 0, 0, 0, 0);
      addEntry(6'h01, 5, 7, 8, 16'h0, 32'h3, 32'hA, 0, 0, 0, 2);
      addEntry(6'h03, 6, 9, 10, 16'h0, 0, 0, 1, 1, 0, 1);
      addEntry(6'h04, 7, 1, 2, 16'h0, 0, 0, 1, 1, 0, 0);
      addEntry(6'h08, 8, 3, 0, 16'hFFF0, 0, 0, 1, 0, 0, 0);
      addEntry(6'h02, 9, 4, 5, 16'h0, 0, 0, 1, 1, 0, 1);   // Carry from addi
      // Dependent chain on consecutive cycles
      addEntry(6'h00, 11, 1, 2, 16'h0, 0, 0, 1, 1, 0, 0);
      addEntry(6'h00, 12, 11, 11, 16'h0, 0, 0, 1, 1, 0, 0);
      addEntry(6'h22, 13, 12, 1, 16'h0, 0, 0, 1, 1, 0, 0);
      addEntry(6'h21, 14, 2, 13, 16'h0, 0, 0, 1, 1, 0, 0);
      addEntry(6'h24, 15, 14, 0, 16'h0041, 0, 0, 1, 0, 0, 0);
      addEntry(6'h04, 0, 1, 2, 16'h0, 0, 0, 1, 1, 0, 0);
      addEntry(6'h00, 16, 0, 0, 16'h0, 0, 0, 1, 1, 0, 2);   // r0 never forwards
      addEntry(6'h20, 17, 1, 2, 16'h0, 0, 0, 1, 1, 0, 1);
      addEntry(6'h23, 18, 1, 2, 16'h0, 0, 0, 1, 1, 0, 0);
      addEntry(6'h29, 19, 1, 0, 16'h8F0F, 0, 0, 1, 0, 0, 1);
      addEntry(6'h2A, 20, 1, 0, 16'h1234, 0, 0, 1, 0, 0, 0);
      addEntry(6'h24, 21, 1, 0, 16'h0001, 32'h80000003, 0, 0, 0, 0, 0);
      addEntry(6'h24, 22, 1, 0, 16'h0021, 32'h00000010, 0, 0, 0, 0, 0);
      addEntry(6'h24, 23, 1, 0, 16'h0021, 0, 0, 1, 0, 0, 1);
      addEntry(6'h24, 24, 1, 0, 16'h0060, 32'h00000080, 0, 0, 0, 0, 0);
      addEntry(6'h24, 25, 1, 0, 16'h0061, 0, 0, 1, 0, 0, 1);
      addEntry(6'h11, 26, 1, 2, 16'h0200, 0, 0, 1, 1, 0, 0);
      // MSR writes and reads
      addEntry(6'h25, 0, 1, 0, 16'h4001, 32'h0000000F, 0, 0, 0, 0, 1);
      addEntry(6'h25, 26, 0, 0, 16'h0001, 0, 0, 0, 0, 0, 0);
      addEntry(6'h25, 27, 0, 0, 16'h0000, 0, 0, 0, 0, 0, 0);
      addEntry(6'h25, 0, 1, 0, 16'h4001, 32'h00000002, 0, 0, 0, 0, 0);
      addEntry(6'h25, 28, 0, 0, 16'h0001, 0, 0, 0, 0, 0, 1);
      // Loads and stores
      addEntry(6'h30, 29, 1, 2, 16'h0, 0, 0, 1, 1, 0, 0);
      addEntry(6'h30, 29, 1, 2, 16'h0, 0, 0, 1, 1, 0, 1);
      addEntry(6'h31, 30, 1, 2, 16'h0, 0, 0, 1, 1, 0, 0);
      addEntry(6'h31, 30, 1, 2, 16'h0, 0, 0, 1, 1, 0, 1);
      addEntry(6'h32, 31, 1, 2, 16'h0, 0, 0, 1, 1, 0, 0);
      addEntry(6'h34, 3, 1, 2, 16'h0, 0, 0, 1, 1, 0, 0);
      addEntry(6'h35, 3, 1, 2, 16'h0, 0, 0, 1, 1, 0, 1);
      addEntry(6'h36, 3, 1, 2, 16'h0, 0, 0, 1, 1, 0, 0);
      addEntry(6'h38, 4, 1, 0, 16'h0003, 0, 0, 1, 0, 0, 0);
      addEntry(6'h39, 4, 1, 0, 16'hFFFE, 0, 0, 1, 0, 0, 0);
      addEntry(6'h3E, 4, 1, 0, 16'h0008, 0, 0, 1, 0, 0, 0);
      addEntry(6'h00, 5, 4, 4, 16'h0, 0, 0, 1, 1, 0, 3);   // Store wrote no register
      for (int i = 0; i < 9; i++) begin
         addEntry(6'h19, 6, 1, 0, 16'((i % 3) << 9), 0, 0, 1, 0, 1, 4'(i % 2));
      end

      repeat (16) @(posedge gclk);
      #1;
      grst = 1'b0;
      repeat (2) @(posedge gclk);
      #1;

      for (int i = 0; i < instrTable.size(); i++) begin
         e = instrTable[i];
         aVal = e.rndA ? nextRand() : e.a;
         bVal = e.rndB ? nextRand() : e.b;
         if (e.rndImm) e.imm[4:0] = 5'(nextRand());
         pcVal = nextRand() & ~32'd3;
         fwdOk = (i > 0) && (instrTable[i - 1].gap == 0);
         opcode = e.op;
         rd = e.rd;
         ra = e.ra;
         rb = e.rb;
         imm = e.imm;
         regA = aVal;
         regB = bVal;
         pc = pcVal;
         issue = 1'b1;
         modelInstr(e, aVal, bVal, pcVal, fwdOk, res, sel);
         expRes.push_back(res);
         expRd.push_back(prevRd);
         expAddr.push_back(res);
         expSel.push_back(sel);
         expIe.push_back(modelIe);
         expCycle.push_back(cycle + 3);   // Sampled next edge, result two edges later
         @(posedge gclk);
         #1;
         issue = 1'b0;
         regA = nextRand();   // Junk outside the issue cycle
         regB = nextRand();
         repeat (e.gap) begin
            @(posedge gclk);
            #1;
         end
      end

      waitCount = 0;
      while (expRes.size() != 0) begin
         @(posedge gclk);
         waitCount = waitCount + 1;
         if (waitCount > 50) begin
            $display("Timeout: results still outstanding at %0t", $time);
            stopRun();
         end
      end
      repeat (4) @(posedge gclk);

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/execTop_assertions.sv
`default_nettype none

module execTop_assertions (
   input wire                    gclk,
   input wire                    grst,
   input wire                    issue,
   input wire xecuPkg::opcode_t  opcode,
   input wire                    resultValid,
   input wire xecuPkg::byteSel_t dataSel,
   input wire                    msrIe
);

   // Issue seen at one edge gives resultValid two edges later
   validLatency: assert property (@(posedge gclk) disable iff (grst)
      resultValid == $past(issue, 3))
      else $error("resultValid does not follow issue by two cycles");

   selOnlyLoadStore: assert property (@(posedge gclk) disable iff (grst)
      (dataSel != 4'h0) |-> ($past(issue, 3) && $past(opcode[5:4], 3) == 2'b11 &&
                             $past(opcode[1:0], 3) != 2'b11))
      else $error("dataSel set without a load or store");

   // Lane pattern has to fit the access size of the issued opcode
   selLegal: assert property (@(posedge gclk) disable iff (grst)
      (dataSel != 4'h0) |->
         (($past(opcode[1:0], 3) == 2'b00 && dataSel inside {4'h8, 4'h4, 4'h2, 4'h1}) ||
          ($past(opcode[1:0], 3) == 2'b01 && dataSel inside {4'hC, 4'h3}) ||
          ($past(opcode[1:0], 3) == 2'b10 && dataSel == 4'hF)))
      else $error("dataSel has an illegal lane pattern");

   noUnknown: assert property (@(posedge gclk) disable iff (grst)
      !$isunknown({resultValid, dataSel, msrIe}))
      else $error("Control output unknown after reset");

endmodule

bind execTop execTop_assertions uAsserts (
   .gclk(gclk), .grst(grst), .issue(issue), .opcode(opcode),
   .resultValid(resultValid), .dataSel(dataSel), .msrIe(msrIe)
);

`default_nettype wire

//--- src/execTop.sv
`default_nettype none

// Issue is taken on a clock edge, resultValid rises two edges later
module execTop (
   input  wire                   gclk,
   input  wire                   grst,
   input  wire                   issue,
   input  wire xecuPkg::opcode_t opcode,
   input  wire xecuPkg::regIdx_t rd,
   input  wire xecuPkg::regIdx_t ra,
   input  wire xecuPkg::regIdx_t rb,
   input  wire xecuPkg::imm_t    imm,
   input  wire xecuPkg::word_t   regA,
   input  wire xecuPkg::word_t   regB,
   input  wire xecuPkg::word_t   pc,
   output xecuPkg::word_t        result,
   output logic                  resultValid,
   output xecuPkg::regIdx_t      resultRd,
   output xecuPkg::word_t        dataAddr,
   output xecuPkg::byteSel_t     dataSel,
   output logic                  msrIe
);

   logic stage1Valid;
   logic stage2Valid;
   xecuPkg::regIdx_t stage1Rd;
   xecuPkg::regIdx_t stage2Rd;
   xecuPkg::unitSel_t unitSel;
   xecuPkg::imm_t immReg;
   logic subFlag;
   logic useCarry;
   logic lsFlag;
   logic [1:0] srcSelA;
   logic [1:0] srcSelB;
   logic [1:0] logicOp;
   logic [1:0] shiftOp;
   logic [1:0] barrelOp;
   logic [1:0] sizeOp;
   logic [1:0] moveSel;
   logic mtsWrite;
   logic carryUpdate;
   logic shiftCarryUpdate;
   xecuPkg::word_t opA;
   xecuPkg::word_t opB;
   xecuPkg::word_t nextResult;
   xecuPkg::word_t msrWord;
   logic carryIn;
   logic carryNext;
   logic msrCarry;
   logic addCarry;
   logic shiftCarry;

   opDecode uDecode (
      .gclk(gclk), .grst(grst), .issue(issue), .opcode(opcode),
      .rd(rd), .ra(ra), .rb(rb), .imm(imm),
      .stage2Valid(stage2Valid), .stage2Rd(stage2Rd),
      .stage1Valid(stage1Valid), .stage1Rd(stage1Rd), .unitSel(unitSel),
      .subFlag(subFlag), .useCarry(useCarry), .srcSelA(srcSelA), .srcSelB(srcSelB),
      .logicOp(logicOp), .shiftOp(shiftOp), .barrelOp(barrelOp), .sizeOp(sizeOp),
      .moveSel(moveSel), .lsFlag(lsFlag), .mtsWrite(mtsWrite),
      .carryUpdate(carryUpdate), .shiftCarryUpdate(shiftCarryUpdate), .immReg(immReg)
   );

   operandSelect uOperands (
      .gclk(gclk), .grst(grst), .stage1Valid(stage1Valid),
      .srcSelA(srcSelA), .srcSelB(srcSelB), .subFlag(subFlag), .useCarry(useCarry),
      .regA(regA), .regB(regB), .pc(pc), .immReg(immReg),
      .fwdResult(nextResult), .carryNext(carryNext),
      .opA(opA), .opB(opB), .carryIn(carryIn)
   );

   execUnit uExec (
      .gclk(gclk), .grst(grst), .opA(opA), .opB(opB), .carryIn(carryIn),
      .unitSel(unitSel), .logicOp(logicOp), .shiftOp(shiftOp), .barrelOp(barrelOp),
      .sizeOp(sizeOp), .moveSel(moveSel), .lsFlag(lsFlag),
      .stage1Valid(stage1Valid), .stage1Rd(stage1Rd),
      .msrWord(msrWord), .msrCarry(msrCarry),
      .nextResult(nextResult), .result(result), .resultValid(resultValid),
      .resultRd(resultRd), .dataAddr(dataAddr), .dataSel(dataSel),
      .addCarry(addCarry), .shiftCarry(shiftCarry),
      .stage2Valid(stage2Valid), .stage2Rd(stage2Rd)
   );

   msrUnit uMsr (
      .gclk(gclk), .grst(grst), .stageValid(stage2Valid),
      .mtsWrite(mtsWrite), .carryUpdate(carryUpdate),
      .shiftCarryUpdate(shiftCarryUpdate), .opA(opA),
      .addCarry(addCarry), .shiftCarry(shiftCarry),
      .carryNext(carryNext), .msrCarry(msrCarry), .msrWord(msrWord), .msrIe(msrIe)
   );

endmodule

`default_nettype wire

//--- src/msrUnit.sv
`default_nettype none

module msrUnit (
   input  wire                 gclk,
   input  wire                 grst,
   input  wire                 stageValid,
   input  wire                 mtsWrite,
   input  wire                 carryUpdate,
   input  wire                 shiftCarryUpdate,
   input  wire xecuPkg::word_t opA,
   input  wire                 addCarry,
   input  wire                 shiftCarry,
   output logic                carryNext,
   output logic                msrCarry,
   output xecuPkg::word_t      msrWord,
   output logic                msrIe
);

   logic msrBe;
   logic msrBip;

   // C as the following instruction sees it
   always_comb begin
      carryNext = msrCarry;
      if (stageValid) begin
         if (carryUpdate) begin
            carryNext = addCarry;
         end else if (shiftCarryUpdate) begin
            carryNext = shiftCarry;
         end else if (mtsWrite) begin
            carryNext = opA[xecuPkg::MsrBitC];
         end
      end
   end

   // Updates on the edge that registers the result
   always_ff @(posedge gclk) begin
      if (grst) begin
         msrCarry <= 1'b0;
         msrIe    <= 1'b0;
         msrBe    <= 1'b0;
         msrBip   <= 1'b0;
      end else if (stageValid) begin
         msrCarry <= carryNext;
         if (mtsWrite) begin
            msrIe  <= opA[xecuPkg::MsrBitIe];
            msrBe  <= opA[xecuPkg::MsrBitBe];
            msrBip <= opA[xecuPkg::MsrBitBip];
         end
      end
   end

   always_comb begin
      msrWord = '0;
      msrWord[31]   = msrCarry;   // C mirrored at the top
      msrWord[27:8] = xecuPkg::MsrVersion;
      msrWord[xecuPkg::MsrBitBip] = msrBip;
      msrWord[xecuPkg::MsrBitC]   = msrCarry;
      msrWord[xecuPkg::MsrBitIe]  = msrIe;
      msrWord[xecuPkg::MsrBitBe]  = msrBe;
   end

endmodule

`default_nettype wire

//--- src/execUnit.sv
`default_nettype none

module execUnit (
   input  wire                    gclk,
   input  wire                    grst,
   input  wire xecuPkg::word_t    opA,
   input  wire xecuPkg::word_t    opB,
   input  wire                    carryIn,
   input  wire xecuPkg::unitSel_t unitSel,
   input  wire [1:0]              logicOp,
   input  wire [1:0]              shiftOp,
   input  wire [1:0]              barrelOp,
   input  wire [1:0]              sizeOp,
   input  wire [1:0]              moveSel,
   input  wire                    lsFlag,
   input  wire                    stage1Valid,
   input  wire xecuPkg::regIdx_t  stage1Rd,
   input  wire xecuPkg::word_t    msrWord,
   input  wire                    msrCarry,
   output xecuPkg::word_t         nextResult,
   output xecuPkg::word_t         result,
   output logic                   resultValid,
   output xecuPkg::regIdx_t       resultRd,
   output xecuPkg::word_t         dataAddr,
   output xecuPkg::byteSel_t      dataSel,
   output logic                   addCarry,
   output logic                   shiftCarry,
   output logic                   stage2Valid,
   output xecuPkg::regIdx_t       stage2Rd
);

   xecuPkg::unitSel_t unitS2;
   logic [1:0] logicS2;
   logic [1:0] shiftS2;
   logic [1:0] barrelS2;
   logic [1:0] sizeS2;
   logic [1:0] moveS2;
   logic lsS2;

   xecuPkg::word_t sum;
   xecuPkg::word_t logicRes;
   xecuPkg::word_t shiftRes;
   xecuPkg::word_t barrelRes;
   xecuPkg::word_t moveRes;
   xecuPkg::byteSel_t laneSel;

   always_ff @(posedge gclk) begin
      if (grst) begin
         stage2Valid <= 1'b0;
      end else begin
         stage2Valid <= stage1Valid;
      end
   end

   // Controls follow the operands into stage 2
   always_ff @(posedge gclk) begin
      if (stage1Valid) begin
         unitS2   <= unitSel;
         logicS2  <= logicOp;
         shiftS2  <= shiftOp;
         barrelS2 <= barrelOp;
         sizeS2   <= sizeOp;
         moveS2   <= moveSel;
         lsS2     <= lsFlag;
         stage2Rd <= stage1Rd;
      end
   end

   assign {addCarry, sum} = {1'b0, opA} + {1'b0, opB} + {32'd0, carryIn};
   assign shiftCarry = opA[0];   // Bit that falls off the right

   always_comb begin
      case (logicS2)
         2'd0:    logicRes = opA | opB;
         2'd1:    logicRes = opA & opB;
         2'd2:    logicRes = opA ^ opB;
         default: logicRes = opA & ~opB;   // andn
      endcase
   end

   always_comb begin
      case (shiftS2)
         2'd0: shiftRes = {opA[31], opA[31:1]};
         2'd1: shiftRes = {msrCarry, opA[31:1]};   // Through carry
         2'd2: shiftRes = {1'b0, opA[31:1]};
         default: begin
            if (sizeS2 == xecuPkg::SizeHalf) begin
               shiftRes = {{16{opA[15]}}, opA[15:0]};
            end else begin
               shiftRes = {{24{opA[7]}}, opA[7:0]};
            end
         end
      endcase
   end

   always_comb begin
      case (barrelS2)
         2'd1:    barrelRes = $signed(opA) >>> opB[4:0];
         2'd2:    barrelRes = opA << opB[4:0];
         default: barrelRes = opA >> opB[4:0];
      endcase
   end

   always_comb begin
      case (moveS2)
         xecuPkg::MoveMsr: moveRes = msrWord;
         xecuPkg::MoveOpB: moveRes = opB;
         default:          moveRes = opA;
      endcase
   end

   always_comb begin
      case (unitS2)
         xecuPkg::unitLogic:  nextResult = logicRes;
         xecuPkg::unitShift:  nextResult = shiftRes;
         xecuPkg::unitMove:   nextResult = moveRes;
         xecuPkg::unitBarrel: nextResult = barrelRes;
         default:             nextResult = sum;
      endcase
   end

   // Lane 0 is the most significant select bit
   always_comb begin
      case (sizeS2)
         xecuPkg::SizeByte: begin
            case (sum[1:0])
               2'd0:    laneSel = 4'h8;
               2'd1:    laneSel = 4'h4;
               2'd2:    laneSel = 4'h2;
               default: laneSel = 4'h1;
            endcase
         end
         xecuPkg::SizeHalf: laneSel = sum[1] ? 4'h3 : 4'hC;
         xecuPkg::SizeWord: laneSel = 4'hF;
         default:           laneSel = 4'h0;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         resultValid <= 1'b0;
         dataSel     <= '0;
      end else begin
         resultValid <= stage2Valid;
         dataSel     <= (stage2Valid && lsS2) ? laneSel : '0;
      end
   end

   always_ff @(posedge gclk) begin
      if (stage2Valid) begin
         result   <= nextResult;
         resultRd <= stage2Rd;
         dataAddr <= sum;
      end
   end

endmodule

`default_nettype wire

//--- src/operandSelect.sv
`default_nettype none

module operandSelect (
   input  wire                 gclk,
   input  wire                 grst,
   input  wire                 stage1Valid,
   input  wire [1:0]           srcSelA,
   input  wire [1:0]           srcSelB,
   input  wire                 subFlag,
   input  wire                 useCarry,
   input  wire xecuPkg::word_t regA,
   input  wire xecuPkg::word_t regB,
   input  wire xecuPkg::word_t pc,
   input  wire xecuPkg::imm_t  immReg,
   input  wire xecuPkg::word_t fwdResult,
   input  wire                 carryNext,
   output xecuPkg::word_t      opA,
   output xecuPkg::word_t      opB,
   output logic                carryIn
);

   xecuPkg::word_t regAHold;
   xecuPkg::word_t regBHold;
   xecuPkg::word_t pcHold;
   xecuPkg::word_t immExt;
   xecuPkg::word_t selA;
   xecuPkg::word_t selB;

   // Values come with issue, a cycle ahead of the decoded selects
   always_ff @(posedge gclk) begin
      regAHold <= regA;
      regBHold <= regB;
      pcHold   <= pc;
   end

   assign immExt = {{16{immReg[15]}}, immReg};

   always_comb begin
      case (srcSelA)
         xecuPkg::SrcFwd: selA = fwdResult;
         xecuPkg::SrcImm: selA = immExt;
         xecuPkg::SrcPc:  selA = pcHold;
         default:         selA = regAHold;
      endcase
      case (srcSelB)
         xecuPkg::SrcFwd: selB = fwdResult;
         xecuPkg::SrcImm: selB = immExt;
         xecuPkg::SrcPc:  selB = pcHold;
         default:         selB = regBHold;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (stage1Valid) begin
         opA <= subFlag ? ~selA : selA;   // B + ~A + 1 is B - A
         opB <= selB;
      end
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         carryIn <= 1'b0;
      end else if (stage1Valid) begin
         carryIn <= useCarry ? carryNext : subFlag;
      end
   end

endmodule

`default_nettype wire

//--- src/opDecode.sv
`default_nettype none

module opDecode (
   input  wire                   gclk,
   input  wire                   grst,
   input  wire                   issue,
   input  wire xecuPkg::opcode_t opcode,
   input  wire xecuPkg::regIdx_t rd,
   input  wire xecuPkg::regIdx_t ra,
   input  wire xecuPkg::regIdx_t rb,
   input  wire xecuPkg::imm_t    imm,
   input  wire                   stage2Valid,
   input  wire xecuPkg::regIdx_t stage2Rd,
   output logic                  stage1Valid,
   output xecuPkg::regIdx_t      stage1Rd,
   output xecuPkg::unitSel_t     unitSel,
   output logic                  subFlag,
   output logic                  useCarry,
   output logic [1:0]            srcSelA,
   output logic [1:0]            srcSelB,
   output logic [1:0]            logicOp,
   output logic [1:0]            shiftOp,
   output logic [1:0]            barrelOp,
   output logic [1:0]            sizeOp,
   output logic [1:0]            moveSel,
   output logic                  lsFlag,
   output logic                  mtsWrite,
   output logic                  carryUpdate,
   output logic                  shiftCarryUpdate,
   output xecuPkg::imm_t         immReg
);

   xecuPkg::opcode_t opReg;
   xecuPkg::regIdx_t rdReg;
   xecuPkg::regIdx_t raReg;
   xecuPkg::regIdx_t rbReg;

   logic addGroup;
   logic logicGroup;
   logic shiftGroup;
   logic moveGroup;
   logic barrelGroup;
   logic lsGroup;
   logic isStore;
   logic isMts;
   logic fwdA;
   logic fwdB;
   logic carryUpdNow;
   logic shiftUpdNow;

   always_ff @(posedge gclk) begin
      if (grst) begin
         stage1Valid <= 1'b0;
      end else begin
         stage1Valid <= issue;
      end
   end

   // Fields held until the next issue
   always_ff @(posedge gclk) begin
      if (issue) begin
         opReg  <= opcode;
         rdReg  <= rd;
         raReg  <= ra;
         rbReg  <= rb;
         immReg <= imm;
      end
   end

   always_comb begin
      addGroup    = (opReg[5:4] == 2'b00);
      barrelGroup = ({opReg[5:4], opReg[2:0]} ==
                     {xecuPkg::OpBarrel[5:4], xecuPkg::OpBarrel[2:0]});
      logicGroup  = (opReg[5:4] == 2'b10) && !opReg[2];
      shiftGroup  = (opReg == xecuPkg::OpShift);
      moveGroup   = (opReg == xecuPkg::OpMoveSpecial);
      lsGroup     = ((opReg & 6'o60) == xecuPkg::OpLoadStoreBase) && (opReg[1:0] != 2'b11);
      isStore     = lsGroup && opReg[2];
      isMts       = moveGroup && immReg[14];
   end

   always_comb begin
      unitSel = xecuPkg::unitAdd;   // Also forms load/store addresses
      if (logicGroup) begin
         unitSel = xecuPkg::unitLogic;
      end else if (shiftGroup) begin
         unitSel = xecuPkg::unitShift;
      end else if (moveGroup) begin
         unitSel = xecuPkg::unitMove;
      end else if (barrelGroup) begin
         unitSel = xecuPkg::unitBarrel;
      end

      subFlag     = addGroup && opReg[0];    // Reverse subtract
      useCarry    = addGroup && opReg[1];
      carryUpdNow = addGroup && !opReg[2];   // Keep forms leave C alone
      shiftUpdNow = shiftGroup && (immReg[6:5] != 2'b11);
      logicOp     = opReg[1:0];
      shiftOp     = immReg[6:5];
      barrelOp    = immReg[10:9];
      sizeOp      = lsGroup ? opReg[1:0] : {1'b0, immReg[0]};
      lsFlag      = lsGroup;

      if (isMts) begin
         moveSel = xecuPkg::MoveOpA;
      end else if (immReg[0]) begin
         moveSel = xecuPkg::MoveMsr;
      end else begin
         moveSel = xecuPkg::MoveOpB;   // pc arrives on B
      end
   end

   // Forward from the instruction now in stage 2, never for r0
   always_comb begin
      fwdA = stage2Valid && (raReg == stage2Rd) && (raReg != '0);
      fwdB = stage2Valid && (rbReg == stage2Rd) && (rbReg != '0);
      srcSelA = fwdA ? xecuPkg::SrcFwd : xecuPkg::SrcReg;
      if (moveGroup && !immReg[14] && !immReg[0]) begin
         srcSelB = xecuPkg::SrcPc;
      end else if (opReg[3]) begin
         srcSelB = xecuPkg::SrcImm;
      end else begin
         srcSelB = fwdB ? xecuPkg::SrcFwd : xecuPkg::SrcReg;
      end
      stage1Rd = (isStore || isMts) ? '0 : rdReg;   // No register write
   end

   // MSR actions travel one stage further with the operands
   always_ff @(posedge gclk) begin
      if (grst) begin
         mtsWrite         <= 1'b0;
         carryUpdate      <= 1'b0;
         shiftCarryUpdate <= 1'b0;
      end else begin
         mtsWrite         <= stage1Valid && isMts;
         carryUpdate      <= stage1Valid && carryUpdNow;
         shiftCarryUpdate <= stage1Valid && shiftUpdNow;
      end
   end

endmodule

`default_nettype wire

//--- src/xecuPkg.sv
`default_nettype none

package xecuPkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  regIdx_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [15:0] imm_t;
   typedef logic [3:0]  byteSel_t;   // Bit 3 is lane 0, big-endian

   // Source of the execute result
   typedef enum logic [2:0] {
      unitAdd,
      unitLogic,
      unitShift,
      unitMove,
      unitBarrel
   } unitSel_t;

   // Opcode groups
   localparam opcode_t OpMoveSpecial   = 6'o45;
   localparam opcode_t OpShift         = 6'o44;
   localparam opcode_t OpBarrel        = 6'o21;   // Bit 3 set gives the immediate form
   localparam opcode_t OpLoadStoreBase = 6'o60;

   // MSR layout
   localparam logic [19:0] MsrVersion = 20'h0ED32;
   localparam int MsrBitBe  = 0;
   localparam int MsrBitIe  = 1;
   localparam int MsrBitC   = 2;
   localparam int MsrBitBip = 3;

   // Operand source selects
   localparam logic [1:0] SrcReg = 2'd0;
   localparam logic [1:0] SrcFwd = 2'd1;
   localparam logic [1:0] SrcImm = 2'd2;
   localparam logic [1:0] SrcPc  = 2'd3;

   // Move selects
   localparam logic [1:0] MoveOpA = 2'd0;
   localparam logic [1:0] MoveOpB = 2'd1;
   localparam logic [1:0] MoveMsr = 2'd2;

   // Access size, also used for sign extension
   localparam logic [1:0] SizeByte = 2'd0;
   localparam logic [1:0] SizeHalf = 2'd1;
   localparam logic [1:0] SizeWord = 2'd2;

endpackage

`default_nettype wire
